// File: logic/raster_pkg.sv
// Raster back end shared definitions
// Fixed-point sizes, screen size, divider timing and post-processor states

package raster_pkg;

    // Signed coordinate words with FRAC_BITS fraction bits
    localparam int DATA_W    = 24;
    localparam int FRAC_BITS = 13;
    localparam int OUT_W     = 12;

    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 320;

    // Matrix element index is row * 4 + column
    localparam int MAT_ADDR_W = 4;
    localparam int MAT_WORDS  = 2 ** MAT_ADDR_W;

    // One quotient bit per shifted-dividend bit, plus the load cycle
    localparam int NUM_W      = DATA_W + FRAC_BITS;
    localparam int DIV_CYCLES = NUM_W + 1;
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);
    localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(DIV_CYCLES - 2);

    // Screen mapping runs in double-fraction fixed point
    localparam int SS_W    = 2 * DATA_W + 1;
    localparam int PIX_LSB = 2 * FRAC_BITS + 1;
    localparam int PIX_MSB = PIX_LSB + OUT_W - 1;
    localparam logic signed [SS_W-1:0] SCREEN_W_FP   = SS_W'(SCREEN_W) << FRAC_BITS;
    localparam logic signed [SS_W-1:0] SCREEN_H_FP   = SS_W'(SCREEN_H) << FRAC_BITS;
    localparam logic signed [SS_W-1:0] SCREEN_W_FP_D = SS_W'(SCREEN_W) << (2 * FRAC_BITS);
    localparam logic signed [SS_W-1:0] SCREEN_H_FP_D = SS_W'(SCREEN_H) << (2 * FRAC_BITS);

    typedef enum logic [2:0] {
        IDLE, CLIP, DIVIDE, SCREEN, ERROR
    } vpp_state_t;

endpackage

// File: logic/fixed_point_divide.sv
// Signed fixed-point divider
// Restoring division on operand magnitudes, one quotient bit per cycle,
// result sign applied at the output so the quotient truncates toward zero
`timescale 1ns/1ns

module fixed_point_divide
    import raster_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_start,
    input  logic signed [DATA_W-1:0] i_dividend,
    input  logic signed [DATA_W-1:0] i_divisor,
    output logic                     o_busy,
    output logic                     o_done,
    output logic signed [DATA_W-1:0] o_quotient,
    output logic                     o_dbz,
    output logic                     o_ovf
);

    // Shifted dividend, turning into the quotient bit by bit
    logic [NUM_W-1:0]     r_nq;
    logic [DATA_W-1:0]    r_rem;
    logic [DATA_W-1:0]    r_div;
    logic                 r_neg;
    logic [DIV_CNT_W-1:0] r_count;
    logic                 r_busy;
    logic                 r_done;

    logic [DATA_W-1:0]    w_dividend_mag;
    logic [DATA_W-1:0]    w_divisor_mag;
    logic [DATA_W:0]      w_trial;
    logic                 w_fits;

    always_comb begin
        w_dividend_mag = i_dividend[DATA_W-1] ? -i_dividend : i_dividend;
        w_divisor_mag  = i_divisor[DATA_W-1] ? -i_divisor : i_divisor;
        // Next partial remainder before the trial subtraction
        w_trial = {r_rem, r_nq[NUM_W-1]};
        w_fits  = (w_trial >= {1'b0, r_div});
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_busy  <= 1'b0;
            r_done  <= 1'b0;
            r_count <= '0;
        end else if (r_done) begin
            r_busy <= 1'b0;
            r_done <= 1'b0;
        end else if (r_busy) begin
            r_count <= r_count + 1'b1;
            r_done  <= (r_count == DIV_LAST);
        end else if (i_start) begin
            r_busy  <= 1'b1;
            r_count <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!r_busy && i_start) begin
            r_nq  <= {w_dividend_mag, {FRAC_BITS{1'b0}}};
            r_rem <= '0;
            r_div <= w_divisor_mag;
            r_neg <= i_dividend[DATA_W-1] ^ i_divisor[DATA_W-1];
        end else if (r_busy && !r_done) begin
            r_nq  <= {r_nq[NUM_W-2:0], w_fits};
            // Restore by keeping the unsubtracted value
            r_rem <= w_fits ? (w_trial[DATA_W-1:0] - r_div) : w_trial[DATA_W-1:0];
        end
    end

    assign o_busy = r_busy;
    assign o_done = r_done;

    assign o_quotient = r_neg ? -$signed(r_nq[DATA_W-1:0]) : $signed(r_nq[DATA_W-1:0]);

    assign o_dbz = (r_div == '0);

    // Magnitude must fit below the sign bit
    assign o_ovf = |r_nq[NUM_W-1:DATA_W-1];

endmodule

// File: logic/vertex_transform.sv
// Vertex transform
// Holds the 4x4 MVP matrix and runs each object-space vertex through it
// with one shared MAC, sixteen cycles per vertex
`timescale 1ns/1ns

module vertex_transform
    import raster_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_mat_we,
    input  logic [MAT_ADDR_W-1:0]    i_mat_addr,
    input  logic signed [DATA_W-1:0] i_mat_data,
    input  logic                     i_vertex_dv,
    input  logic signed [DATA_W-1:0] i_vertex_x,
    input  logic signed [DATA_W-1:0] i_vertex_y,
    input  logic signed [DATA_W-1:0] i_vertex_z,
    input  logic signed [DATA_W-1:0] i_vertex_w,
    input  logic                     i_vpp_ready,
    output logic                     o_ready,
    output logic                     o_clip_dv,
    output logic signed [DATA_W-1:0] o_clip_x,
    output logic signed [DATA_W-1:0] o_clip_y,
    output logic signed [DATA_W-1:0] o_clip_z,
    output logic signed [DATA_W-1:0] o_clip_w
);

    typedef enum logic [1:0] {
        XF_IDLE,
        XF_MAC,
        XF_HOLD
    } xf_state_t;

    xf_state_t r_state;

    logic signed [DATA_W-1:0]   r_mat [MAT_WORDS];
    logic signed [DATA_W-1:0]   r_vtx [4];
    logic signed [DATA_W-1:0]   r_clip [4];
    logic signed [DATA_W-1:0]   r_acc;
    // Matrix element index, column in the low two bits
    logic [MAT_ADDR_W-1:0]      r_idx;

    logic signed [2*DATA_W-1:0] w_prod;
    logic signed [DATA_W-1:0]   w_sum;

    always_comb begin
        w_prod = r_mat[r_idx] * r_vtx[r_idx[1:0]];
        // Shift out the extra fraction bits, wrap at DATA_W
        w_sum = r_acc + $signed(w_prod[DATA_W+FRAC_BITS-1:FRAC_BITS]);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < MAT_WORDS; i++) begin
                r_mat[i] <= '0;
            end
        end else if (i_mat_we) begin
            r_mat[i_mat_addr] <= i_mat_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_state <= XF_IDLE;
            r_idx   <= '0;
        end else begin
            case (r_state)
                XF_IDLE: begin
                    if (i_vertex_dv) begin
                        r_state <= XF_MAC;
                        r_idx   <= '0;
                    end
                end
                XF_MAC: begin
                    r_idx <= r_idx + 1'b1;
                    if (r_idx == '1) begin
                        r_state <= XF_HOLD;
                    end
                end
                // Stall here until the post processor takes the result
                XF_HOLD: begin
                    if (i_vpp_ready) begin
                        r_state <= XF_IDLE;
                    end
                end
                default: r_state <= XF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_state == XF_IDLE && i_vertex_dv) begin
            r_vtx[0] <= i_vertex_x;
            r_vtx[1] <= i_vertex_y;
            r_vtx[2] <= i_vertex_z;
            r_vtx[3] <= i_vertex_w;
            r_acc    <= '0;
        end else if (r_state == XF_MAC) begin
            if (r_idx[1:0] == 2'd3) begin
                r_clip[r_idx[3:2]] <= w_sum;
                r_acc              <= '0;
            end else begin
                r_acc <= w_sum;
            end
        end
    end

    assign o_ready   = (r_state == XF_IDLE);
    assign o_clip_dv = (r_state == XF_HOLD) && i_vpp_ready;
    assign o_clip_x  = r_clip[0];
    assign o_clip_y  = r_clip[1];
    assign o_clip_z  = r_clip[2];
    assign o_clip_w  = r_clip[3];

endmodule

// File: logic/vertex_post_processor.sv
// Vertex post processor
// Rejects vertices outside 0 < z < w, divides x, y and z by w and maps
// the normalized result to pixel coordinates and depth
`timescale 1ns/1ns

module vertex_post_processor
    import raster_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_clip_dv,
    input  logic signed [DATA_W-1:0] i_clip_x,
    input  logic signed [DATA_W-1:0] i_clip_y,
    input  logic signed [DATA_W-1:0] i_clip_z,
    input  logic signed [DATA_W-1:0] i_clip_w,
    output logic                     o_ready,
    output logic [OUT_W-1:0]         o_pixel_x,
    output logic [OUT_W-1:0]         o_pixel_y,
    output logic [OUT_W-1:0]         o_depth,
    output logic                     o_done,
    output logic                     o_invalid
);

    vpp_state_t r_state;
    vpp_state_t w_next;

    logic signed [DATA_W-1:0] r_clip_x;
    logic signed [DATA_W-1:0] r_clip_y;
    logic signed [DATA_W-1:0] r_clip_z;
    logic signed [DATA_W-1:0] r_clip_w;

    logic signed [DATA_W-1:0] w_ndc_x;
    logic signed [DATA_W-1:0] w_ndc_y;
    logic signed [DATA_W-1:0] w_ndc_z;
    logic                     w_x_busy;
    logic                     w_y_busy;
    logic                     w_z_busy;
    logic                     w_x_done;
    logic                     w_y_done;
    logic                     w_z_done;
    logic                     w_x_dbz;
    logic                     w_y_dbz;
    logic                     w_z_dbz;
    logic                     w_x_ovf;
    logic                     w_y_ovf;
    logic                     w_z_ovf;

    logic                     w_depth_pass;
    logic                     w_div_start;
    logic                     w_div_done;
    logic                     w_div_err;
    logic signed [SS_W-1:0]   w_ss_x;
    logic signed [SS_W-1:0]   w_ss_y;

    always_comb begin
        w_depth_pass = (r_clip_z > 0) && (r_clip_w > r_clip_z);
        // All three dividers idle only on the first DIVIDE cycle
        w_div_start = (r_state == DIVIDE) && !(w_x_busy || w_y_busy || w_z_busy);
        w_div_done  = w_x_done && w_y_done && w_z_done;
        w_div_err   = w_x_dbz || w_y_dbz || w_z_dbz || w_x_ovf || w_y_ovf || w_z_ovf;
        // (ndc + 1) * W and (1 - ndc) * H with 2 * FRAC_BITS fraction bits
        w_ss_x = w_ndc_x * SCREEN_W_FP + SCREEN_W_FP_D;
        w_ss_y = SCREEN_H_FP_D - w_ndc_y * SCREEN_H_FP;
    end

    always_comb begin
        w_next = r_state;
        case (r_state)
            IDLE:    w_next = i_clip_dv ? CLIP : IDLE;
            CLIP:    w_next = w_depth_pass ? DIVIDE : ERROR;
            DIVIDE:  w_next = w_div_done ? SCREEN : DIVIDE;
            SCREEN:  w_next = w_div_err ? ERROR : IDLE;
            ERROR:   w_next = IDLE;
            default: w_next = IDLE;
        endcase
    end

    // Done is raised on entry to ERROR, or on leaving a good SCREEN step
    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_state   <= IDLE;
            o_done    <= 1'b0;
            o_invalid <= 1'b0;
        end else begin
            r_state   <= w_next;
            o_done    <= (w_next == ERROR) || (r_state == SCREEN);
            o_invalid <= (w_next == ERROR);
        end
    end

    always_ff @(posedge clk) begin
        if (r_state == IDLE && i_clip_dv) begin
            r_clip_x <= i_clip_x;
            r_clip_y <= i_clip_y;
            r_clip_z <= i_clip_z;
            r_clip_w <= i_clip_w;
        end
        // Rejected vertices leave the last pixel in place
        if (r_state == SCREEN && !w_div_err) begin
            o_pixel_x <= w_ss_x[PIX_MSB:PIX_LSB];
            o_pixel_y <= w_ss_y[PIX_MSB:PIX_LSB];
            o_depth   <= w_ndc_z[FRAC_BITS-1:FRAC_BITS-OUT_W];
        end
    end

    assign o_ready = (r_state == IDLE);

    fixed_point_divide i_divide_x (
        .clk        (clk),
        .rstn       (rstn),
        .i_start    (w_div_start),
        .i_dividend (r_clip_x),
        .i_divisor  (r_clip_w),
        .o_busy     (w_x_busy),
        .o_done     (w_x_done),
        .o_quotient (w_ndc_x),
        .o_dbz      (w_x_dbz),
        .o_ovf      (w_x_ovf)
    );

    fixed_point_divide i_divide_y (
        .clk        (clk),
        .rstn       (rstn),
        .i_start    (w_div_start),
        .i_dividend (r_clip_y),
        .i_divisor  (r_clip_w),
        .o_busy     (w_y_busy),
        .o_done     (w_y_done),
        .o_quotient (w_ndc_y),
        .o_dbz      (w_y_dbz),
        .o_ovf      (w_y_ovf)
    );

    fixed_point_divide i_divide_z (
        .clk        (clk),
        .rstn       (rstn),
        .i_start    (w_div_start),
        .i_dividend (r_clip_z),
        .i_divisor  (r_clip_w),
        .o_busy     (w_z_busy),
        .o_done     (w_z_done),
        .o_quotient (w_ndc_z),
        .o_dbz      (w_z_dbz),
        .o_ovf      (w_z_ovf)
    );

endmodule

// File: logic/vertex_pipeline.sv
// Vertex pipeline top level
// Matrix transform followed by clip test, perspective divide and screen mapping
`timescale 1ns/1ns

module vertex_pipeline
    import raster_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_mat_we,
    input  logic [MAT_ADDR_W-1:0]    i_mat_addr,
    input  logic signed [DATA_W-1:0] i_mat_data,
    input  logic                     i_vertex_dv,
    input  logic signed [DATA_W-1:0] i_vertex_x,
    input  logic signed [DATA_W-1:0] i_vertex_y,
    input  logic signed [DATA_W-1:0] i_vertex_z,
    input  logic signed [DATA_W-1:0] i_vertex_w,
    output logic                     o_ready,
    output logic [OUT_W-1:0]         o_pixel_x,
    output logic [OUT_W-1:0]         o_pixel_y,
    output logic [OUT_W-1:0]         o_depth,
    output logic                     o_done,
    output logic                     o_invalid
);

    // Clip-space vertex handed from transform to post processor
    logic                     w_clip_dv;
    logic signed [DATA_W-1:0] w_clip_x;
    logic signed [DATA_W-1:0] w_clip_y;
    logic signed [DATA_W-1:0] w_clip_z;
    logic signed [DATA_W-1:0] w_clip_w;
    logic                     w_vpp_ready;

    vertex_transform i_vertex_transform (
        .clk         (clk),
        .rstn        (rstn),
        .i_mat_we    (i_mat_we),
        .i_mat_addr  (i_mat_addr),
        .i_mat_data  (i_mat_data),
        .i_vertex_dv (i_vertex_dv),
        .i_vertex_x  (i_vertex_x),
        .i_vertex_y  (i_vertex_y),
        .i_vertex_z  (i_vertex_z),
        .i_vertex_w  (i_vertex_w),
        .i_vpp_ready (w_vpp_ready),
        .o_ready     (o_ready),
        .o_clip_dv   (w_clip_dv),
        .o_clip_x    (w_clip_x),
        .o_clip_y    (w_clip_y),
        .o_clip_z    (w_clip_z),
        .o_clip_w    (w_clip_w)
    );

    vertex_post_processor i_vertex_post_processor (
        .clk       (clk),
        .rstn      (rstn),
        .i_clip_dv (w_clip_dv),
        .i_clip_x  (w_clip_x),
        .i_clip_y  (w_clip_y),
        .i_clip_z  (w_clip_z),
        .i_clip_w  (w_clip_w),
        .o_ready   (w_vpp_ready),
        .o_pixel_x (o_pixel_x),
        .o_pixel_y (o_pixel_y),
        .o_depth   (o_depth),
        .o_done    (o_done),
        .o_invalid (o_invalid)
    );

endmodule

// File: test/vertex_pipeline_assertions.sv
// Vertex pipeline protocol checks
// Bound to the top level, watches the vertex strobe, ready, done and invalid
`timescale 1ns/1ns

module vertex_pipeline_assertions (
    input logic clk,
    input logic rstn,
    input logic i_vertex_dv,
    input logic o_ready,
    input logic o_done,
    input logic o_invalid
);

    // Set once a vertex has been accepted since reset
    logic r_accepted;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_accepted <= 1'b0;
        end else if (i_vertex_dv && o_ready) begin
            r_accepted <= 1'b1;
        end
    end

    invalid_needs_done: assert property (@(posedge clk) disable iff (!rstn)
        o_invalid |-> o_done)
        else $error("o_invalid high without o_done");

    done_single_cycle: assert property (@(posedge clk) disable iff (!rstn)
        o_done |=> !o_done)
        else $error("o_done high for two cycles in a row");

    strobe_only_when_ready: assert property (@(posedge clk) disable iff (!rstn)
        i_vertex_dv |-> o_ready)
        else $error("i_vertex_dv high while o_ready is low");

    no_done_before_vertex: assert property (@(posedge clk) disable iff (!rstn)
        o_done |-> r_accepted)
        else $error("o_done raised before any vertex was accepted");

endmodule

bind vertex_pipeline vertex_pipeline_assertions i_vertex_pipeline_assertions (
    .clk         (clk),
    .rstn        (rstn),
    .i_vertex_dv (i_vertex_dv),
    .o_ready     (o_ready),
    .o_done      (o_done),
    .o_invalid   (o_invalid)
);

// File: test/tb_vertex_pipeline.sv
// Vertex pipeline testbench
// Directed tests against a fixed-point model of the transform, clip test,
// perspective divide and screen mapping
`timescale 1ns/1ns

module tb_vertex_pipeline
    import raster_pkg::*;
();

    localparam int NUM_VERTICES   = 22;
    localparam int TIMEOUT_CYCLES = NUM_VERTICES * (DIV_CYCLES + 40) + 200;
    localparam logic signed [DATA_W-1:0] ONE = DATA_W'(1 << FRAC_BITS);

    logic                     clk;
    logic                     rstn;
    logic                     i_mat_we;
    logic [MAT_ADDR_W-1:0]    i_mat_addr;
    logic signed [DATA_W-1:0] i_mat_data;
    logic                     i_vertex_dv;
    logic signed [DATA_W-1:0] i_vertex_x;
    logic signed [DATA_W-1:0] i_vertex_y;
    logic signed [DATA_W-1:0] i_vertex_z;
    logic signed [DATA_W-1:0] i_vertex_w;
    logic                     o_ready;
    logic [OUT_W-1:0]         o_pixel_x;
    logic [OUT_W-1:0]         o_pixel_y;
    logic [OUT_W-1:0]         o_depth;
    logic                     o_done;
    logic                     o_invalid;

    // Model copy of the matrix and the expected results in order
    logic signed [DATA_W-1:0] mat_ref [MAT_WORDS];
    logic [3*OUT_W:0]         expect_q [$];
    logic [OUT_W-1:0]         held_px;
    logic [OUT_W-1:0]         held_py;
    logic [OUT_W-1:0]         held_dep;
    logic [31:0]              rng;
    int                       cycle_count = 0;
    string                    cur_test;

    vertex_pipeline i_vertex_pipeline (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // One row of the matrix times the vertex, products shifted before the sum
    function automatic logic signed [DATA_W-1:0] transform_row(input int row,
            input logic signed [DATA_W-1:0] vx, vy, vz, vw);
        logic signed [DATA_W-1:0]   v [4];
        logic signed [DATA_W-1:0]   acc;
        logic signed [2*DATA_W-1:0] prod;
        v[0] = vx;
        v[1] = vy;
        v[2] = vz;
        v[3] = vw;
        acc  = '0;
        for (int c = 0; c < 4; c++) begin
            prod = mat_ref[row * 4 + c] * v[c];
            acc  = acc + DATA_W'(prod >>> FRAC_BITS);
        end
        return acc;
    endfunction

    // Quotient truncated toward zero, returns high on divide by zero or overflow
    function automatic logic divide_ref(input logic signed [DATA_W-1:0] num, den,
                                        output logic signed [DATA_W-1:0] quo);
        longint n_mag;
        longint d_mag;
        longint q_mag;
        n_mag = (num < 0) ? -longint'(num) : longint'(num);
        d_mag = (den < 0) ? -longint'(den) : longint'(den);
        quo   = '0;
        if (d_mag == 0) begin
            return 1'b1;
        end
        q_mag = (n_mag << FRAC_BITS) / d_mag;
        quo   = ((num < 0) != (den < 0)) ? DATA_W'(-q_mag) : DATA_W'(q_mag);
        return q_mag >= (longint'(1) << (DATA_W - 1));
    endfunction

    task automatic predict(input logic signed [DATA_W-1:0] x, y, z, w);
        logic signed [DATA_W-1:0] cx, cy, cz, cw;
        logic signed [DATA_W-1:0] nx, ny, nz;
        logic                     bad;
        longint                   ss_x;
        longint                   ss_y;
        cx  = transform_row(0, x, y, z, w);
        cy  = transform_row(1, x, y, z, w);
        cz  = transform_row(2, x, y, z, w);
        cw  = transform_row(3, x, y, z, w);
        bad = !(cz > 0 && cw > cz);
        if (!bad) begin
            bad = divide_ref(cx, cw, nx);
            bad = divide_ref(cy, cw, ny) || bad;
            bad = divide_ref(cz, cw, nz) || bad;
        end
        if (!bad) begin
            // Floor of (ndc + 1) * W / 2 and (1 - ndc) * H / 2
            ss_x = (longint'(nx) + (longint'(1) << FRAC_BITS)) * SCREEN_W;
            ss_y = ((longint'(1) << FRAC_BITS) - longint'(ny)) * SCREEN_H;
            held_px  = OUT_W'(ss_x >>> (FRAC_BITS + 1));
            held_py  = OUT_W'(ss_y >>> (FRAC_BITS + 1));
            held_dep = nz[FRAC_BITS-1 -: OUT_W];
        end
        expect_q.push_back({bad, held_px, held_py, held_dep});
    endtask

    task automatic write_matrix();
        for (int i = 0; i < MAT_WORDS; i++) begin
            @(posedge clk);
            i_mat_we   <= 1'b1;
            i_mat_addr <= MAT_ADDR_W'(i);
            i_mat_data <= mat_ref[i];
        end
        @(posedge clk);
        i_mat_we <= 1'b0;
    endtask

    task automatic send_vertex(input logic signed [DATA_W-1:0] x, y, z, w);
        @(negedge clk);
        while (!o_ready) @(negedge clk);
        predict(x, y, z, w);
        @(posedge clk);
        i_vertex_dv <= 1'b1;
        i_vertex_x  <= x;
        i_vertex_y  <= y;
        i_vertex_z  <= z;
        i_vertex_w  <= w;
        @(posedge clk);
        i_vertex_dv <= 1'b0;
        @(negedge clk);
        check_value("ready after accept", 0, o_ready);
    endtask

    task automatic wait_result();
        logic [3*OUT_W:0] exp;
        @(negedge clk);
        while (!o_done) @(negedge clk);
        exp = expect_q.pop_front();
        check_value("invalid", exp[3*OUT_W], o_invalid);
        check_value("pixel x", exp[3*OUT_W-1 -: OUT_W], o_pixel_x);
        check_value("pixel y", exp[2*OUT_W-1 -: OUT_W], o_pixel_y);
        check_value("depth", exp[OUT_W-1:0], o_depth);
    endtask

    task automatic random_vertex(output logic signed [DATA_W-1:0] x, y, z, w);
        rng = xorshift(rng);
        x   = DATA_W'(int'(rng[13:0]) - 8192);
        y   = DATA_W'(int'(rng[27:14]) - 8192);
        rng = xorshift(rng);
        z   = DATA_W'(rng[12:0]);
        w   = ONE + DATA_W'(rng[25:13]);
    endtask

    task automatic test_identity_center();
        cur_test = "identity_center";
        for (int i = 0; i < MAT_WORDS; i++) begin
            mat_ref[i] = (i / 4 == i % 4) ? ONE : '0;
        end
        write_matrix();
        send_vertex(0, 0, ONE / 2, ONE);
        wait_result();
        check_value("fixed pixel x", 160, o_pixel_x);
        check_value("fixed pixel y", 160, o_pixel_y);
        check_value("fixed depth", 2048, o_depth);
        check_value("fixed invalid", 0, o_invalid);
    endtask

    task automatic test_depth_clip();
        int z_list [4] = '{0, -4096, 8192, 10240};
        cur_test = "depth_clip";
        for (int i = 0; i < 4; i++) begin
            send_vertex(ONE / 4, -ONE / 4, DATA_W'(z_list[i]), ONE);
            wait_result();
            check_value("clip invalid", 1, o_invalid);
        end
    endtask

    task automatic test_divide_overflow();
        cur_test = "divide_overflow";
        // x over w is 2048.0, beyond the quotient range
        send_vertex(DATA_W'(1 << 22), 0, ONE / 8, ONE / 4);
        wait_result();
        check_value("overflow invalid", 1, o_invalid);
    endtask

    task automatic test_matrix_random();
        logic signed [DATA_W-1:0] x, y, z, w;
        cur_test = "matrix_random";
        for (int i = 0; i < MAT_WORDS; i++) begin
            mat_ref[i] = '0;
        end
        mat_ref[0]  = ONE / 2;
        mat_ref[3]  = ONE / 8;
        mat_ref[5]  = 3 * ONE / 4;
        mat_ref[7]  = -ONE / 4;
        mat_ref[10] = ONE / 2;
        mat_ref[11] = ONE / 4;
        mat_ref[15] = ONE;
        write_matrix();
        repeat (8) begin
            random_vertex(x, y, z, w);
            send_vertex(x, y, z, w);
            wait_result();
        end
    endtask

    task automatic test_back_to_back();
        logic signed [DATA_W-1:0] x, y, z, w;
        cur_test = "back_to_back";
        fork
            repeat (8) begin
                random_vertex(x, y, z, w);
                send_vertex(x, y, z, w);
            end
            repeat (8) wait_result();
        join
    endtask

    initial begin
        rstn        = 1'b0;
        i_mat_we    = 1'b0;
        i_mat_addr  = '0;
        i_mat_data  = '0;
        i_vertex_dv = 1'b0;
        i_vertex_x  = '0;
        i_vertex_y  = '0;
        i_vertex_z  = '0;
        i_vertex_w  = '0;
        rng         = 32'h883e;
        held_px     = '0;
        held_py     = '0;
        held_dep    = '0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        test_identity_center();
        test_depth_clip();
        test_divide_overflow();
        test_matrix_random();
        test_back_to_back();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: build.f
logic/raster_pkg.sv
logic/fixed_point_divide.sv
logic/vertex_transform.sv
logic/vertex_post_processor.sv
logic/vertex_pipeline.sv
test/vertex_pipeline_assertions.sv
test/tb_vertex_pipeline.sv
